// ==== ixt_config.svh ====
// Sizing macros for the register mask and the microcode ROM
`ifndef IXT_CONFIG_SVH
`define IXT_CONFIG_SVH

// ====================
// Register list
// ====================

// Width of the register mask carried in the imm field of a multiple access
`define REG_MASK_BITS 13

// ====================
// Microcode
// ====================

// Every microcode sequence plays exactly this many instructions
`define UC_SEQ_LEN 4
// Four entry points of UC_SEQ_LEN words each
`define UC_ROM_DEPTH 16

`endif

// ==== ixt_pkg.sv ====
// Opcode enum, instruction and interrupt request structs, register sentinel
`include "ixt_config.svh"

package ixt_pkg;

	// ====================
	// Opcodes
	// ====================

	// The escape opcodes LDM, STM and UCODE never reach decode directly
	typedef enum logic [6:0] {
		OP_NOP   = 7'h00,
		OP_ADD   = 7'h04,
		OP_LD    = 7'h10,
		OP_ST    = 7'h11,
		OP_LDM   = 7'h12,
		OP_STM   = 7'h13,
		OP_SYS   = 7'h20,
		OP_UCODE = 7'h3f
	} op_t;

	// Architectural register number
	typedef logic [5:0] aregno_t;

	// All ones marks an empty register slot
	localparam aregno_t AREG_NONE = 6'h3f;

	// Top bit of imm in an injected system call flags a hardware interrupt
	localparam logic FN_IRQ = 1'b1;

	// ====================
	// Structs
	// ====================

	// Field order from the top matches the 32-bit instruction word
	typedef struct packed {
		logic [`REG_MASK_BITS-1:0] imm;
		aregno_t                   rs1;
		aregno_t                   rd;
		op_t                       op;
	} instruction_t;

	// Priority level and vector of a hardware interrupt request
	typedef struct packed {
		logic [2:0] level;
		logic [8:0] vect;
	} irq_req_t;

endpackage

// ==== irq_inject.sv ====
// Interrupt request latch with pending and in-service tracking
`timescale 1ns/1ps

module irq_inject (
	input  logic              clk,
	input  logic              rst,
	input  ixt_pkg::irq_req_t irq_i,
	input  logic [2:0]        irq_mask_i,
	input  logic              take_i,
	output logic              pending_o,
	output ixt_pkg::irq_req_t req_o
);
	import ixt_pkg::*;

	logic     pending_q;
	logic     in_service_q;
	irq_req_t req_q;
	logic     qualify;

	// A request counts only when its level is strictly above the mask
	assign qualify = irq_i.level > irq_mask_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			pending_q    <= 1'b0;
			in_service_q <= 1'b0;
		end else begin
			if (pending_q) begin
				// Hold the request until the mux has put it in a slot
				if (take_i) begin
					pending_q    <= 1'b0;
					in_service_q <= 1'b1;
				end
			end else if (in_service_q) begin
				// Re-arm only once the source has dropped its level
				if (irq_i.level == 3'd0)
					in_service_q <= 1'b0;
			end else if (qualify) begin
				pending_q <= 1'b1;
			end
		end
	end

	// The captured request stays frozen while pending or in service
	always_ff @(posedge clk) begin
		if (!pending_q && !in_service_q && qualify)
			req_q <= irq_i;
	end

	assign pending_o = pending_q;
	assign req_o     = req_q;

endmodule

// ==== reglist_seq.sv ====
// Register mask walker for load-multiple and store-multiple expansion
`timescale 1ns/1ps
`include "ixt_config.svh"

module reglist_seq (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  en_i,
	input  logic                  start_i,
	input  ixt_pkg::instruction_t ins_i,
	output logic                  busy_o,
	output ixt_pkg::instruction_t held_o,
	output ixt_pkg::aregno_t      reg_o,
	output ixt_pkg::aregno_t      count_o
);
	import ixt_pkg::*;

	logic [`REG_MASK_BITS-1:0] mask_q;
	instruction_t              held_q;
	aregno_t                   count_q;

	// ====================
	// Mask and count
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			mask_q  <= '0;
			count_q <= '0;
		end else if (start_i) begin
			// The mask travels in the imm field of the escape instruction
			mask_q  <= ins_i.imm;
			count_q <= '0;
		end else if (en_i && busy_o) begin
			// Subtracting one and masking clears exactly the lowest set bit
			mask_q  <= mask_q & (mask_q - 1'b1);
			count_q <= count_q + 1'b1;
		end
	end

	// Opcode and the other fields are reused for every expanded access
	always_ff @(posedge clk) begin
		if (start_i)
			held_q <= ins_i;
	end

	// ====================
	// Lowest set bit
	// ====================

	// Scan from the top so the last hit is the lowest register number
	always_comb begin
		reg_o = AREG_NONE;
		for (int i = `REG_MASK_BITS - 1; i >= 0; i--) begin
			if (mask_q[i])
				reg_o = aregno_t'(i);
		end
	end

	// An empty mask means the expansion is over or never began
	assign busy_o  = |mask_q;
	assign held_o  = held_q;
	assign count_o = count_q;

endmodule

// ==== ucode_seq.sv ====
// Microcode ROM with a fixed-length sequence player
`timescale 1ns/1ps
`include "ixt_config.svh"

module ucode_seq (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  en_i,
	input  logic                  start_i,
	input  logic [1:0]            entry_i,
	output logic                  busy_o,
	output ixt_pkg::instruction_t uc_ins_o
);
	import ixt_pkg::*;

	localparam int ADDR_W = $clog2(`UC_ROM_DEPTH);
	localparam int STEP_W = $clog2(`UC_SEQ_LEN);

	typedef enum logic {
		IDLE,
		RUN
	} uc_state_t;

	logic [31:0]       rom [0:`UC_ROM_DEPTH-1];
	uc_state_t         state_q;
	logic [STEP_W-1:0] step_q;
	logic [ADDR_W-1:0] base_q;
	logic [ADDR_W-1:0] addr;

	// ROM image is shared with the testbench model
	initial begin
		$readmemh("ucode_rom.mem", rom);
	end

	// ====================
	// Sequencer
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= IDLE;
			step_q  <= '0;
		end else if (start_i) begin
			state_q <= RUN;
			step_q  <= '0;
		end else if (en_i && state_q == RUN) begin
			step_q <= step_q + 1'b1;
			// The last word has just gone out on this advance
			if (step_q == STEP_W'(`UC_SEQ_LEN - 1))
				state_q <= IDLE;
		end
	end

	// Each entry selects a block of UC_SEQ_LEN consecutive words
	always_ff @(posedge clk) begin
		if (start_i)
			base_q <= ADDR_W'(entry_i * `UC_SEQ_LEN);
	end

	assign addr     = base_q + ADDR_W'(step_q);
	assign busy_o   = state_q == RUN;
	assign uc_ins_o = instruction_t'(rom[addr]);

endmodule

// ==== ins_extract_mux.sv ====
// Instruction slot selector with list rewrite, interrupt injection and start strobes
`timescale 1ns/1ps
`include "ixt_config.svh"

module ins_extract_mux (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  en_i,
	input  ixt_pkg::instruction_t ins_i,
	input  logic                  pack_regs_i,
	input  logic [2:0]            scale_regs_i,
	input  logic                  pending_i,
	input  ixt_pkg::irq_req_t     irq_req_i,
	input  logic                  list_busy_i,
	input  ixt_pkg::instruction_t held_i,
	input  ixt_pkg::aregno_t      reg_i,
	input  ixt_pkg::aregno_t      count_i,
	input  logic                  uc_busy_i,
	input  ixt_pkg::instruction_t uc_ins_i,
	output logic                  irq_take_o,
	output logic                  start_list_o,
	output logic                  start_uc_o,
	output logic [1:0]            uc_entry_o,
	output logic                  stall_o,
	output ixt_pkg::instruction_t ins_o
);
	import ixt_pkg::*;

	localparam instruction_t NOP_INS = '{imm: '0, rs1: '0, rd: '0, op: OP_NOP};

	logic                      seq_busy;
	logic                      accept;
	logic                      is_list;
	logic [`REG_MASK_BITS-1:0] offset;
	instruction_t              list_ins;
	instruction_t              irq_ins;
	instruction_t              next_ins;

	// ====================
	// Slot arbitration
	// ====================

	assign seq_busy = list_busy_i | uc_busy_i;
	// An interrupt takes the first free slot ahead of fetch
	assign irq_take_o = en_i & ~seq_busy & pending_i;
	assign accept     = en_i & ~seq_busy & ~pending_i;
	assign is_list    = ins_i.op == OP_LDM || ins_i.op == OP_STM;

	assign start_list_o = accept & is_list;
	assign start_uc_o   = accept & (ins_i.op == OP_UCODE);
	assign uc_entry_o   = ins_i.imm[1:0];

	// Fetch holds its instruction while anything else owns the slot
	assign stall_o = seq_busy | pending_i;

	// ====================
	// Slot contents
	// ====================

	// Offset base is either the register number or the running count
	assign offset = `REG_MASK_BITS'(pack_regs_i ? count_i : reg_i) << scale_regs_i;

	always_comb begin
		list_ins     = held_i;
		list_ins.imm = offset;
		// A store names its data register in rs1, a load in rd
		if (held_i.op == OP_STM) begin
			list_ins.op  = OP_ST;
			list_ins.rs1 = reg_i;
		end else begin
			list_ins.op = OP_LD;
			list_ins.rd = reg_i;
		end
	end

	// System call with the vector split across rs1 and imm
	assign irq_ins = '{
		imm: {FN_IRQ, 3'd0, irq_req_i.vect[8:6], 3'd0, irq_req_i.level},
		rs1: irq_req_i.vect[5:0],
		rd:  '0,
		op:  OP_SYS
	};

	always_comb begin
		if (list_busy_i)
			next_ins = list_ins;
		else if (uc_busy_i)
			next_ins = uc_ins_i;
		else if (pending_i)
			next_ins = irq_ins;
		else if (is_list || ins_i.op == OP_UCODE)
			next_ins = NOP_INS;
		else
			next_ins = ins_i;
	end

	always_ff @(posedge clk) begin
		if (rst)
			ins_o <= NOP_INS;
		else if (en_i)
			ins_o <= next_ins;
	end

endmodule

// ==== ins_extract_top.sv ====
// Extract stage top with the interrupt, list and microcode sources and the slot mux
`timescale 1ns/1ps

module ins_extract_top (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  en_i,
	input  ixt_pkg::instruction_t ins_i,
	input  ixt_pkg::irq_req_t     irq_i,
	input  logic [2:0]            irq_mask_i,
	input  logic                  pack_regs_i,
	input  logic [2:0]            scale_regs_i,
	output logic                  stall_o,
	output ixt_pkg::instruction_t ins_o
);
	import ixt_pkg::*;

	logic         pending;
	logic         irq_take;
	irq_req_t     irq_req;
	logic         start_list;
	logic         list_busy;
	instruction_t held;
	aregno_t      list_reg;
	aregno_t      list_count;
	logic         start_uc;
	logic [1:0]   uc_entry;
	logic         uc_busy;
	instruction_t uc_ins;

	// Interrupt source
	irq_inject u_irq (
		.clk(clk), .rst(rst), .irq_i(irq_i), .irq_mask_i(irq_mask_i),
		.take_i(irq_take), .pending_o(pending), .req_o(irq_req)
	);

	// Load/store-multiple expansion
	reglist_seq u_list (
		.clk(clk), .rst(rst), .en_i(en_i), .start_i(start_list), .ins_i(ins_i),
		.busy_o(list_busy), .held_o(held), .reg_o(list_reg), .count_o(list_count)
	);

	// Microcode playback
	ucode_seq u_uc (
		.clk(clk), .rst(rst), .en_i(en_i), .start_i(start_uc), .entry_i(uc_entry),
		.busy_o(uc_busy), .uc_ins_o(uc_ins)
	);

	// Slot selection and output register
	ins_extract_mux u_mux (
		.clk(clk), .rst(rst), .en_i(en_i), .ins_i(ins_i),
		.pack_regs_i(pack_regs_i), .scale_regs_i(scale_regs_i),
		.pending_i(pending), .irq_req_i(irq_req),
		.list_busy_i(list_busy), .held_i(held), .reg_i(list_reg), .count_i(list_count),
		.uc_busy_i(uc_busy), .uc_ins_i(uc_ins),
		.irq_take_o(irq_take), .start_list_o(start_list), .start_uc_o(start_uc),
		.uc_entry_o(uc_entry), .stall_o(stall_o), .ins_o(ins_o)
	);

endmodule

// ==== tb_ins_extract.sv ====
// Testbench for the extract stage with reference model, output monitor, comparer and stimulus
`timescale 1ns/1ps
`include "ixt_config.svh"

module tb_ins_extract;
	import ixt_pkg::*;

	localparam int DRIVE_LIMIT = 2000;
	localparam int ROM_AW = $clog2(`UC_ROM_DEPTH);
	localparam instruction_t NOP_WORD = '{imm: '0, rs1: '0, rd: '0, op: OP_NOP};

	logic         clk;
	logic         rst;
	logic         en_i;
	instruction_t ins_i;
	irq_req_t     irq_i;
	logic [2:0]   irq_mask_i;
	logic         pack_regs_i;
	logic [2:0]   scale_regs_i;
	logic         stall_o;
	instruction_t ins_o;

	logic [31:0]  rom_img [0:`UC_ROM_DEPTH-1];
	instruction_t exp_q[$];
	instruction_t got_q[$];
	instruction_t fetch_q[$];
	instruction_t last_ins;
	irq_req_t     exp_irq;
	logic         en_seen;
	logic         live;
	int           errors;
	int           tests_run;
	int           tests_failed;
	int           errors_at_start;
	int           stall_cycles;
	string        test_name;

	ins_extract_top u_dut (
		.clk(clk), .rst(rst), .en_i(en_i), .ins_i(ins_i), .irq_i(irq_i),
		.irq_mask_i(irq_mask_i), .pack_regs_i(pack_regs_i),
		.scale_regs_i(scale_regs_i), .stall_o(stall_o), .ins_o(ins_o)
	);

	always #20 clk = ~clk;

	// ====================
	// Reference model
	// ====================

	// Appends the ins_o values that one accepted fetch should produce
	function automatic void expected_stream(instruction_t f, logic pack, logic [2:0] scale);
		instruction_t e;
		logic [12:0]  bits;
		logic [12:0]  base;
		int           count;
		int           entry;
		exp_q.push_back(NOP_WORD);
		if (f.op == OP_LDM || f.op == OP_STM) begin
			bits  = f.imm;
			count = 0;
			// Walk the mask from register zero upward
			for (int r = 0; r < `REG_MASK_BITS; r++) begin
				if (bits[0]) begin
					e = f;
					if (f.op == OP_LDM) begin
						e.op = OP_LD;
						e.rd = aregno_t'(r);
					end else begin
						e.op  = OP_ST;
						e.rs1 = aregno_t'(r);
					end
					base  = pack ? 13'(count) : 13'(r);
					e.imm = base << scale;
					exp_q.push_back(e);
					count++;
				end
				bits = bits >> 1;
			end
		end else if (f.op == OP_UCODE) begin
			entry = int'(f.imm[1:0]);
			for (int k = 0; k < `UC_SEQ_LEN; k++) begin
				exp_q.push_back(instruction_t'(rom_img[ROM_AW'(entry * `UC_SEQ_LEN + k)]));
			end
		end else begin
			// Plain instructions replace the NOP pushed above
			void'(exp_q.pop_back());
			exp_q.push_back(f);
		end
	endfunction

	// An injected call flags the interrupt in imm and splits the vector over rs1 and imm
	function automatic instruction_t sys_call(irq_req_t r);
		instruction_t e;
		e     = NOP_WORD;
		e.op  = OP_SYS;
		e.rs1 = r.vect[5:0];
		e.imm = {FN_IRQ, 3'b000, r.vect[8:6], 3'b000, r.level};
		return e;
	endfunction

	function automatic irq_req_t decode_irq(instruction_t i);
		irq_req_t d;
		d.level = i.imm[2:0];
		d.vect  = {i.imm[8:6], i.rs1};
		return d;
	endfunction

	// ====================
	// Checks
	// ====================

	task automatic check_ins(string name, instruction_t exp, instruction_t act);
		if (act !== exp) begin
			errors++;
			$display("FAIL %s: expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_irq(string name, irq_req_t exp, irq_req_t act);
		if (act !== exp) begin
			errors++;
			$display("FAIL %s: expected level %0d vect %h actual level %0d vect %h",
				name, exp.level, exp.vect, act.level, act.vect);
		end
	endtask

	// Advances are seen at the rising edge, ins_o is read at the next falling edge
	always @(posedge clk) begin
		en_seen <= en_i & ~rst;
		live    <= ~rst;
	end

	always @(negedge clk) begin
		if (en_seen) begin
			got_q.push_back(ins_o);
		end else if (live && ins_o !== last_ins) begin
			errors++;
			$display("ERROR %s: ins_o changed while en_i was low", test_name);
		end
		last_ins = ins_o;
	end

	// Recorded outputs are matched against the model in order
	always @(posedge clk) begin : compare_outputs
		instruction_t got;
		instruction_t exp;
		while (got_q.size() > 0) begin
			got = got_q.pop_front();
			if (exp_q.size() == 0) begin
				errors++;
				$display("ERROR %s: output %h arrived with nothing expected", test_name, got);
			end else begin
				exp = exp_q.pop_front();
				check_ins(test_name, exp, got);
				if (exp.op == OP_SYS)
					check_irq(test_name, exp_irq, decode_irq(got));
			end
		end
	end

	// ====================
	// Stimulus helpers
	// ====================

	task automatic abort_run(string why);
		$display("ERROR %s: %s", test_name, why);
		$display("*** TEST FAILED ***");
		$finish;
	endtask

	function automatic instruction_t make_ins(op_t op, logic [12:0] imm);
		instruction_t r;
		r.op  = op;
		r.imm = imm;
		r.rs1 = aregno_t'($urandom);
		r.rd  = aregno_t'($urandom);
		return r;
	endfunction

	function automatic instruction_t rand_plain();
		op_t op;
		case ($urandom_range(3))
			0: op = OP_NOP;
			1: op = OP_ADD;
			2: op = OP_LD;
			default: op = OP_ST;
		endcase
		return make_ins(op, 13'($urandom));
	endfunction

	function automatic logic [12:0] rand_mask();
		logic [12:0] m;
		m = 13'($urandom);
		if (m == '0)
			m = 13'h1;
		return m;
	endfunction

	task automatic idle(int n);
		repeat (n) begin
			@(negedge clk);
			en_i = 1'b0;
		end
	endtask

	task automatic begin_test(string name);
		test_name       = name;
		errors_at_start = errors;
		tests_run++;
		fetch_q.delete();
	endtask

	task automatic finish_test();
		idle(2);
		if (errors > errors_at_start) begin
			tests_failed++;
			$display("test %s: %0d errors", test_name, errors - errors_at_start);
		end else begin
			$display("test %s: ok", test_name);
		end
	endtask

	// Plays fetch_q like a fetch unit and raises req after entry irq_after is taken
	task automatic run_fetch(int irq_after, irq_req_t req);
		int   idx;
		int   cycles;
		logic raise;
		for (int i = 0; i < fetch_q.size(); i++) begin
			expected_stream(fetch_q[i], pack_regs_i, scale_regs_i);
			if (i == irq_after)
				exp_q.push_back(sys_call(req));
		end
		exp_irq      = req;
		idx          = 0;
		cycles       = 0;
		raise        = 1'b0;
		stall_cycles = 0;
		while (idx < fetch_q.size() || exp_q.size() > 0) begin
			@(negedge clk);
			cycles++;
			if (cycles > DRIVE_LIMIT)
				abort_run("outputs stopped before the expected stream was complete");
			if (raise) begin
				irq_i = req;
				raise = 1'b0;
			end
			en_i = ($urandom_range(3) != 0);
			if (stall_o)
				stall_cycles++;
			if (idx < fetch_q.size()) begin
				ins_i = fetch_q[idx];
				// Fetch moves on only once the stage has accepted its instruction
				if (en_i && !stall_o) begin
					raise = (idx == irq_after);
					idx++;
				end
			end else begin
				ins_i = NOP_WORD;
				en_i  = en_i & stall_o;
			end
		end
		en_i = 1'b0;
	endtask

	// ====================
	// Test sequence
	// ====================

	initial begin : stimulus
		irq_req_t req;
		void'($urandom(32'he200e116));
		$readmemh("ucode_rom.mem", rom_img);
		clk          = 1'b0;
		rst          = 1'b1;
		en_i         = 1'b0;
		ins_i        = NOP_WORD;
		irq_i        = '0;
		irq_mask_i   = 3'd2;
		pack_regs_i  = 1'b0;
		scale_regs_i = 3'd0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		test_name    = "reset";
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		begin_test("reset");
		check_ins("reset", NOP_WORD, ins_o);
		if (stall_o !== 1'b0) begin
			errors++;
			$display("ERROR reset: stall_o is not low after reset");
		end
		finish_test();

		begin_test("plain");
		repeat (12) fetch_q.push_back(rand_plain());
		run_fetch(-1, '0);
		if (stall_cycles != 0) begin
			errors++;
			$display("ERROR plain: stall_o went high during plain instructions");
		end
		finish_test();

		begin_test("list");
		scale_regs_i = 3'($urandom_range(7));
		fetch_q.push_back(make_ins(OP_LDM, rand_mask()));
		fetch_q.push_back(rand_plain());
		fetch_q.push_back(make_ins(OP_STM, rand_mask()));
		fetch_q.push_back(rand_plain());
		run_fetch(-1, '0);
		finish_test();

		// Offsets now come from the running count, and an empty mask is included
		begin_test("list_packed");
		pack_regs_i  = 1'b1;
		scale_regs_i = 3'($urandom_range(7));
		fetch_q.push_back(make_ins(OP_STM, rand_mask()));
		fetch_q.push_back(make_ins(OP_LDM, rand_mask()));
		fetch_q.push_back(make_ins(OP_LDM, 13'h0));
		fetch_q.push_back(rand_plain());
		run_fetch(-1, '0);
		pack_regs_i = 1'b0;
		finish_test();

		begin_test("ucode");
		for (int e = 0; e < 4; e++) begin
			fetch_q.push_back(make_ins(OP_UCODE, {11'($urandom), 2'(e)}));
			fetch_q.push_back(rand_plain());
		end
		run_fetch(-1, '0);
		finish_test();

		begin_test("irq_inject");
		req.level = 3'(3 + $urandom_range(4));
		req.vect  = 9'($urandom);
		fetch_q.push_back(make_ins(OP_LDM, rand_mask()));
		fetch_q.push_back(rand_plain());
		fetch_q.push_back(rand_plain());
		run_fetch(0, req);
		finish_test();

		// The request from the previous test is still held high
		begin_test("irq_held");
		repeat (6) fetch_q.push_back(rand_plain());
		run_fetch(-1, irq_i);
		finish_test();

		begin_test("irq_masked");
		irq_i.level = 3'd0;
		idle(3);
		irq_i.level = 3'(1 + $urandom_range(1));
		irq_i.vect  = 9'($urandom);
		repeat (6) fetch_q.push_back(rand_plain());
		run_fetch(-1, irq_i);
		finish_test();

		$display("tests run %0d, tests failed %0d, check errors %0d",
			tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== ucode_rom.mem ====
// One 32-bit instruction word per line, fields imm[31:19] rs1[18:13] rd[12:7] op[6:0]
// Four sequences of four words, entry n starts at word 4n
00402204
00084290
0010a311
00000000
01006384
0002c410
00204511
00186604
00008010
0040e891
00016a04
00000000
01f1ec84
00120f10
0008a111
00302304

// ==== tb.f ====
+incdir+.
ixt_pkg.sv
irq_inject.sv
reglist_seq.sv
ucode_seq.sv
ins_extract_mux.sv
ins_extract_top.sv
tb_ins_extract.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the extract stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f tb.f --top-module tb_ins_extract -o tb_ins_extract
if [ $? -ne 0 ]; then
	echo "Compilation failed"
	exit 1
fi

./obj_dir/tb_ins_extract > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG"; then
	exit 1
fi
exit 0
